//--- source/memPkg.sv
package memPkg;

    localparam int SRAM_DEPTH = 1024;
    localparam int SRAM_AW = $clog2(SRAM_DEPTH);
    localparam int EXT_DEPTH = 4096;
    localparam int EXT_AW = $clog2(EXT_DEPTH);
    localparam int BURST_LEN = 16;
    localparam int WORD_BYTES = 4;

    typedef logic [29:0] wordAddr_t;
    typedef logic [31:0] word_t;
    typedef logic [WORD_BYTES-1:0] byteMask_t;
    typedef logic [SRAM_AW-1:0] sramAddr_t;
    typedef logic [31:0] extAddr_t;
    typedef logic [9:0] progress_t;
    typedef logic [7:0] char_t;

    // stores to this word become console characters
    localparam wordAddr_t CONSOLE_ADDR = 30'h3F800000;
    localparam byteMask_t CONSOLE_MASK = 4'b0001;
    localparam byteMask_t FULL_MASK = '1;

    // one port-0 access with active-low strobes
    typedef struct packed {
        logic ceN;
        logic weN;
        byteMask_t wm;
        wordAddr_t addr;
        word_t data;
    } memReq_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,  // external memory into the SRAM
        STORE  // SRAM out to external memory
    } xferState_t;

endpackage

//--- source/extMemory.sv
`timescale 1ns/1ps

module extMemory import memPkg::*; (
    input logic clk,
    input logic ceN,
    input logic weN,
    input extAddr_t addr,
    input word_t wdata,
    output word_t rdata
);

    word_t mem [EXT_DEPTH];
    logic [EXT_AW-1:0] idx;

    assign idx = addr[EXT_AW-1:0];  // upper address bits wrap around

    always_ff @(posedge clk) begin
        if (!ceN) begin
            if (!weN) begin
                mem[idx] <= wdata;
            end else begin
                rdata <= mem[idx];  // data is there one cycle after the enable
            end
        end
    end

endmodule

//--- source/transferEngine.sv
`timescale 1ns/1ps

module transferEngine import memPkg::*; (
    input logic clk,
    input logic rstN,
    input logic xferCeN,
    input logic xferWeN,
    input sramAddr_t xferSramAddr,
    input extAddr_t xferExtAddr,
    input word_t sramRdata,
    input word_t extRdata,
    output memReq_t engineReq,
    output logic engineUsed,
    output logic busy,
    output progress_t progress,
    output logic extCeN,
    output logic extWeN,
    output extAddr_t extAddr,
    output word_t extWdata
);

    xferState_t state;
    logic [$clog2(BURST_LEN):0] rdCnt;  // words read so far in this burst
    sramAddr_t rdSram;
    extAddr_t rdExt;
    logic wrValid;  // a word read last cycle is written this cycle
    sramAddr_t wrSram;
    extAddr_t wrExt;
    logic active;
    logic rdActive;

    assign active = state != IDLE;
    assign rdActive = active && (rdCnt < BURST_LEN);
    assign busy = active;
    assign engineUsed = active;  // the engine owns port 0 for the whole burst

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= IDLE;
            rdCnt <= '0;
            wrValid <= 1'b0;
            progress <= '0;
        end else if (state == IDLE) begin
            wrValid <= 1'b0;
            if (!xferCeN) begin
                state <= xferWeN ? STORE : LOAD;
                rdCnt <= '0;
                progress <= '0;
            end
        end else begin
            wrValid <= rdActive;
            if (rdActive) begin
                rdCnt <= rdCnt + 1'b1;
            end
            if (wrValid) begin
                progress <= progress + 1'b1;
            end
            if (!rdActive) begin
                state <= IDLE;  // only the last write was left in flight
            end
        end
    end

    // addresses advance by one word per read and wrap at the memory sizes
    always_ff @(posedge clk) begin
        if (state == IDLE && !xferCeN) begin
            rdSram <= xferSramAddr;
            rdExt <= xferExtAddr;
        end else if (rdActive) begin
            rdSram <= rdSram + 1'b1;
            rdExt <= rdExt + 1'b1;
        end
        wrSram <= rdSram;
        wrExt <= rdExt;
    end

    always_comb begin
        engineReq.ceN = 1'b1;
        engineReq.weN = 1'b1;
        engineReq.wm = FULL_MASK;
        engineReq.addr = wordAddr_t'(rdSram);
        engineReq.data = extRdata;
        extCeN = 1'b1;
        extWeN = 1'b1;
        extAddr = rdExt;
        extWdata = sramRdata;

        if (state == LOAD) begin
            extCeN = !rdActive;
            engineReq.ceN = !wrValid;
            engineReq.weN = !wrValid;
            engineReq.addr = wordAddr_t'(wrSram);
        end else if (state == STORE) begin
            engineReq.ceN = !rdActive;  // SRAM read on port 0
            extCeN = !wrValid;
            extWeN = !wrValid;
            extAddr = wrExt;
        end
    end

endmodule

//--- source/dataSram.sv
`timescale 1ns/1ps

module dataSram import memPkg::*; (
    input logic clk,
    input memReq_t req,
    input logic readEnN,
    input sramAddr_t readAddr,
    output word_t rdata0,
    output word_t rdata1
);

    word_t mem [SRAM_DEPTH];
    sramAddr_t idx0;

    assign idx0 = req.addr[SRAM_AW-1:0];  // range was already checked upstream

    // port 0 reads or writes with the bytes merged under the mask
    always_ff @(posedge clk) begin
        if (!req.ceN) begin
            if (!req.weN) begin
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (req.wm[b]) begin
                        mem[idx0][b*8 +: 8] <= req.data[b*8 +: 8];
                    end
                end
            end else begin
                rdata0 <= mem[idx0];
            end
        end
    end

    // port 1 is read only and belongs to the core
    always_ff @(posedge clk) begin
        if (!readEnN) begin
            rdata1 <= mem[readAddr];
        end
    end

endmodule

//--- source/memPortArbiter.sv
`timescale 1ns/1ps

module memPortArbiter import memPkg::*; (
    input logic clk,
    input logic rstN,
    input logic engineUsed,
    input memReq_t engineReq,
    input memReq_t coreReq,
    output memReq_t sramReq,
    output logic consoleValid,
    output char_t consoleChar
);

    logic coreInRange;
    logic consoleHit;

    assign coreInRange = coreReq.addr < SRAM_DEPTH;

    // the console snoops core stores whoever owns the port
    assign consoleHit = !coreReq.ceN && !coreReq.weN
        && coreReq.wm == CONSOLE_MASK && coreReq.addr == CONSOLE_ADDR;

    always_comb begin
        if (engineUsed) begin
            sramReq = engineReq;  // core traffic is dropped without a stall
        end else begin
            sramReq = coreReq;
            if (!coreInRange) begin
                sramReq.ceN = 1'b1;  // out of range stores vanish
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            consoleValid <= 1'b0;
        end else begin
            consoleValid <= consoleHit;
        end
    end

    always_ff @(posedge clk) begin
        if (consoleHit) begin
            consoleChar <= coreReq.data[7:0];
        end
    end

endmodule

//--- source/memSubsystem.sv
`timescale 1ns/1ps

module memSubsystem import memPkg::*; (
    input logic clk,
    input logic rstN,
    input memReq_t coreReq,
    input logic coreReadEnN,
    input sramAddr_t coreReadAddr,
    input logic xferCeN,
    input logic xferWeN,
    input sramAddr_t xferSramAddr,
    input extAddr_t xferExtAddr,
    output word_t coreReadData,
    output logic busy,
    output progress_t progress,
    output logic consoleValid,
    output char_t consoleChar
);

    memReq_t engineReq;
    memReq_t sramReq;
    logic engineUsed;
    word_t sramRdata0;
    logic extCeN;
    logic extWeN;
    extAddr_t extAddr;
    word_t extWdata;
    word_t extRdata;

    transferEngine transferEngine_i (
        .clk(clk),
        .rstN(rstN),
        .xferCeN(xferCeN),
        .xferWeN(xferWeN),
        .xferSramAddr(xferSramAddr),
        .xferExtAddr(xferExtAddr),
        .sramRdata(sramRdata0),
        .extRdata(extRdata),
        .engineReq(engineReq),
        .engineUsed(engineUsed),
        .busy(busy),
        .progress(progress),
        .extCeN(extCeN),
        .extWeN(extWeN),
        .extAddr(extAddr),
        .extWdata(extWdata)
    );

    extMemory extMemory_i (
        .clk(clk),
        .ceN(extCeN),
        .weN(extWeN),
        .addr(extAddr),
        .wdata(extWdata),
        .rdata(extRdata)
    );

    // port 0 is shared with the engine, port 1 serves core loads
    dataSram dataSram_i (
        .clk(clk),
        .req(sramReq),
        .readEnN(coreReadEnN),
        .readAddr(coreReadAddr),
        .rdata0(sramRdata0),
        .rdata1(coreReadData)
    );

    memPortArbiter memPortArbiter_i (
        .clk(clk),
        .rstN(rstN),
        .engineUsed(engineUsed),
        .engineReq(engineReq),
        .coreReq(coreReq),
        .sramReq(sramReq),
        .consoleValid(consoleValid),
        .consoleChar(consoleChar)
    );

endmodule

//--- bench/memSubsystemTb.sv
`timescale 1ns/1ps

module memSubsystemTb import memPkg::*; ();

    localparam int N_RANDOM = 40;
    localparam int N_OUTSIDE = 8;
    localparam int N_CONSOLE = 8;
    localparam int N_XFER = 4;
    localparam int N_BLOCKED = 6;  // must fit inside one burst at two cycles per write
    localparam int NUM_OPS = 2 * N_RANDOM + 2 * N_OUTSIDE + N_CONSOLE + 1
        + N_XFER + (N_XFER + 1) * BURST_LEN + N_BLOCKED + 1;
    localparam int WATCHDOG_CYCLES = NUM_OPS * (BURST_LEN + 4) + 200;
    localparam memReq_t IDLE_REQ = '{ceN: 1'b1, weN: 1'b1, wm: '0, addr: '0, data: '0};

    logic clk;
    logic rstN;
    memReq_t coreReq;
    logic coreReadEnN;
    sramAddr_t coreReadAddr;
    logic xferCeN;
    logic xferWeN;
    sramAddr_t xferSramAddr;
    extAddr_t xferExtAddr;
    word_t coreReadData;
    logic busy;
    progress_t progress;
    logic consoleValid;
    char_t consoleChar;

    word_t shadow [SRAM_DEPTH];  // what the SRAM should hold
    word_t extCopy [EXT_DEPTH];  // what the external memory should hold
    byteMask_t otherMasks [4] = '{4'b0011, 4'b1111, 4'b0010, 4'b0000};
    int seed;
    int errors;
    int opCount;
    string testName;

    logic readPending;
    word_t expRead;
    logic expConsole;
    char_t expChar;
    int busyLeft;  // cycles of busy still expected
    progress_t expProgress;
    logic busyWas;
    int busyRun;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    memSubsystem memSubsystem_i (
        .clk(clk),
        .rstN(rstN),
        .coreReq(coreReq),
        .coreReadEnN(coreReadEnN),
        .coreReadAddr(coreReadAddr),
        .xferCeN(xferCeN),
        .xferWeN(xferWeN),
        .xferSramAddr(xferSramAddr),
        .xferExtAddr(xferExtAddr),
        .coreReadData(coreReadData),
        .busy(busy),
        .progress(progress),
        .consoleValid(consoleValid),
        .consoleChar(consoleChar)
    );

    function automatic word_t mergeBytes(word_t old, word_t data, byteMask_t wm);
        word_t merged;
        merged = old;
        for (int b = 0; b < WORD_BYTES; b++) begin
            if (wm[b]) begin
                merged[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    function automatic logic isConsoleWrite(memReq_t req);
        return !req.ceN && !req.weN && req.wm == 4'b0001 && req.addr == CONSOLE_ADDR;
    endfunction

    function automatic int wrapSram(sramAddr_t base, int offset);
        return (int'(base) + offset) % SRAM_DEPTH;
    endfunction

    function automatic int wrapExt(extAddr_t base, int offset);
        return (int'(base[EXT_AW-1:0]) + offset) % EXT_DEPTH;  // only the low bits count
    endfunction

    task automatic reportMismatch(string what, word_t expected, word_t actual);
        errors++;
        $display("ERROR %s (%s): expected %h, actual %h", testName, what, expected, actual);
    endtask

    // reference model that follows the port and transfer rules cycle by cycle
    always @(posedge clk) begin
        if (!rstN) begin
            readPending <= 1'b0;
            expConsole <= 1'b0;
            busyLeft <= 0;
            expProgress <= '0;
            busyWas <= 1'b0;
            busyRun <= 0;
        end else begin
            readPending <= !coreReadEnN;
            expRead <= shadow[coreReadAddr];
            expConsole <= isConsoleWrite(coreReq);
            expChar <= coreReq.data[7:0];
            busyWas <= busy;
            busyRun <= busy ? busyRun + 1 : 0;
            if (busyLeft == 0 && !coreReq.ceN && !coreReq.weN && coreReq.addr < SRAM_DEPTH) begin
                shadow[coreReq.addr[SRAM_AW-1:0]] <=
                    mergeBytes(shadow[coreReq.addr[SRAM_AW-1:0]], coreReq.data, coreReq.wm);
            end
            if (busyLeft != 0) begin
                busyLeft <= busyLeft - 1;
                if (busyLeft <= BURST_LEN) begin
                    expProgress <= expProgress + 1'b1;  // one write lands per cycle
                end
            end else if (!xferCeN) begin
                busyLeft <= BURST_LEN + 1;
                expProgress <= '0;
                for (int i = 0; i < BURST_LEN; i++) begin
                    if (!xferWeN) begin
                        shadow[wrapSram(xferSramAddr, i)] <= extCopy[wrapExt(xferExtAddr, i)];
                    end else begin
                        extCopy[wrapExt(xferExtAddr, i)] <= shadow[wrapSram(xferSramAddr, i)];
                    end
                end
            end
        end
    end

    portOneRead: assert property (@(posedge clk) disable iff (!rstN)
        readPending |-> coreReadData == expRead)
        else reportMismatch("port 1 read", $sampled(expRead), $sampled(coreReadData));

    consoleStrobe: assert property (@(posedge clk) disable iff (!rstN)
        consoleValid == expConsole)
        else reportMismatch("console valid", $sampled(expConsole), $sampled(consoleValid));

    consoleByte: assert property (@(posedge clk) disable iff (!rstN)
        expConsole |-> consoleChar == expChar)
        else reportMismatch("console char", $sampled(expChar), $sampled(consoleChar));

    busyLevel: assert property (@(posedge clk) disable iff (!rstN)
        busy == (busyLeft != 0))
        else reportMismatch("busy level", $sampled(busyLeft != 0), $sampled(busy));

    busyLength: assert property (@(posedge clk) disable iff (!rstN)
        (busyWas && !busy) |-> busyRun == BURST_LEN + 1)
        else reportMismatch("busy cycles", BURST_LEN + 1, $sampled(busyRun));

    progressCount: assert property (@(posedge clk) disable iff (!rstN)
        progress == expProgress)
        else reportMismatch("progress", $sampled(expProgress), $sampled(progress));

    finalProgress: assert property (@(posedge clk) disable iff (!rstN)
        (busyWas && !busy) |-> progress == BURST_LEN)
        else reportMismatch("final progress", BURST_LEN, $sampled(progress));

    task automatic beginTest(string name);
        repeat (2) @(posedge clk);  // lets checks of the previous test retire first
        testName = name;
    endtask

    task automatic coreWrite(wordAddr_t addr, word_t data, byteMask_t wm);
        @(posedge clk);
        coreReq <= '{ceN: 1'b0, weN: 1'b0, wm: wm, addr: addr, data: data};
        @(posedge clk);
        coreReq <= IDLE_REQ;
        opCount++;
    endtask

    task automatic coreRead(sramAddr_t addr);
        @(posedge clk);
        coreReadEnN <= 1'b0;
        coreReadAddr <= addr;
        @(posedge clk);
        coreReadEnN <= 1'b1;
        opCount++;
    endtask

    task automatic startTransfer(logic isLoad, sramAddr_t sramBase, extAddr_t extBase);
        @(posedge clk);
        xferCeN <= 1'b0;
        xferWeN <= !isLoad;
        xferSramAddr <= sramBase;
        xferExtAddr <= extBase;
        @(posedge clk);
        xferCeN <= 1'b1;
        opCount++;
    endtask

    task automatic waitIdle();
        do begin
            @(negedge clk);
        end while (busy);
    endtask

    task automatic readRegion(sramAddr_t base);
        for (int i = 0; i < BURST_LEN; i++) begin
            coreRead(sramAddr_t'(wrapSram(base, i)));
        end
    endtask

    initial begin
        word_t data;
        wordAddr_t addr;
        byteMask_t mask;
        sramAddr_t base;
        sramAddr_t other;
        extAddr_t extBase;
        seed = 78;
        errors = 0;
        opCount = 0;
        testName = "reset";
        rstN <= 1'b0;
        coreReq <= IDLE_REQ;
        coreReadEnN <= 1'b1;
        coreReadAddr <= '0;
        xferCeN <= 1'b1;
        xferWeN <= 1'b1;
        xferSramAddr <= '0;
        xferExtAddr <= '0;
        // both memories start with known random contents
        for (int i = 0; i < SRAM_DEPTH; i++) begin
            shadow[i] = $random(seed);
            memSubsystem_i.dataSram_i.mem[i] = shadow[i];
        end
        for (int i = 0; i < EXT_DEPTH; i++) begin
            extCopy[i] = $random(seed);
            memSubsystem_i.extMemory_i.mem[i] = extCopy[i];
        end
        repeat (2) @(posedge clk);
        rstN <= 1'b1;

        beginTest("masked writes");
        repeat (N_RANDOM) begin
            base = sramAddr_t'($random(seed));
            data = $random(seed);
            mask = byteMask_t'($random(seed));
            coreWrite(wordAddr_t'(base), data, mask);
            coreRead(base);
        end

        beginTest("out of range writes");
        repeat (N_OUTSIDE) begin
            addr = wordAddr_t'($random(seed));
            if (addr < SRAM_DEPTH) begin
                addr[20] = 1'b1;
            end
            if (addr == CONSOLE_ADDR) begin
                addr = addr + 1'b1;
            end
            coreWrite(addr, $random(seed), 4'b1111);
            coreRead(addr[SRAM_AW-1:0]);  // the aliased index must keep its old word
        end

        beginTest("console output");
        for (int i = 0; i < N_CONSOLE; i++) begin
            mask = (i % 2 == 0) ? 4'b0001 : otherMasks[i / 2];
            coreWrite(CONSOLE_ADDR, $random(seed), mask);
        end
        coreWrite(CONSOLE_ADDR + 1'b1, 32'h41, 4'b0001);

        beginTest("load transfer");
        base = sramAddr_t'($random(seed));
        extBase = $random(seed);
        startTransfer(1'b1, base, extBase);
        waitIdle();
        readRegion(base);

        beginTest("store then reload");
        base = sramAddr_t'(SRAM_DEPTH - 6);  // both sides wrap inside the burst
        extBase = extAddr_t'(EXT_DEPTH - 3);
        startTransfer(1'b0, base, extBase);
        waitIdle();
        other = sramAddr_t'(200 + ($random(seed) & 511));
        startTransfer(1'b1, other, extBase);
        waitIdle();
        readRegion(other);
        readRegion(base);

        beginTest("writes during transfer");
        base = sramAddr_t'($random(seed));
        extBase = $random(seed);
        startTransfer(1'b1, base, extBase);
        for (int i = 0; i < N_BLOCKED; i++) begin
            coreWrite(wordAddr_t'(wrapSram(base, 2 * i)), $random(seed), 4'b1111);
        end
        coreWrite(CONSOLE_ADDR, 32'h21, 4'b0001);  // console is still served mid burst
        waitIdle();
        readRegion(base);

        repeat (4) @(posedge clk);
        $display("operations: %0d, errors: %0d", opCount, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("TIMEOUT: the run hung and was stopped after %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- sim.f
source/memPkg.sv
source/extMemory.sv
source/transferEngine.sv
source/dataSram.sv
source/memPortArbiter.sv
source/memSubsystem.sv
bench/memSubsystemTb.sv
